/* include/dense_settings.svh */
`ifndef DENSE_SETTINGS_SVH
`define DENSE_SETTINGS_SVH

// batch rows handled in parallel, one dot unit each
`define DENSE_N 2

// words per hidden vector and per weight row
`define DENSE_HID_DIM 4

// output characters, one weight row each
`define DENSE_CHAR_NUM 3

// fixed-point word width
`define DENSE_N_LEN 16

// Q8.8 format
`define DENSE_FRAC_BITS 8

// multiply, shift, two add levels
`define DENSE_DOT_STAGES 4

`endif

/* verilog/dense_pkg.sv */
`default_nettype none

`include "dense_settings.svh"

package dense_pkg;

  // one signed fixed-point word
  typedef logic signed [`DENSE_N_LEN-1:0] word_t;

  // hidden vector or weight row, element 0 in the low bits
  typedef word_t [`DENSE_HID_DIM-1:0] hid_vec_t;

  // wide enough to count up to DENSE_CHAR_NUM itself
  typedef logic [$clog2(`DENSE_CHAR_NUM + 1)-1:0] char_idx_t;

  // sequencer of the dense layer
  typedef enum logic [2:0] {
    ST_IDLE,   // waiting for host req
    ST_FETCH,  // weight row handshake with the ROM
    ST_ISSUE,  // one cycle, row goes into the dot units
    ST_DRAIN,  // waiting for the last scores
    ST_DONE    // ack high until req drops
  } layer_state_e;

endpackage

`default_nettype wire

/* verilog/weight_fetch_if.sv */
`default_nettype none

// four-phase weight row fetch between sequencer and ROM
interface weight_fetch_if;

  logic                 req;  // held until ack seen
  dense_pkg::char_idx_t idx;  // stable while req is high
  logic                 ack;
  dense_pkg::hid_vec_t  row;  // valid while ack is high

  modport requester (
    output req,
    output idx,
    input  ack,
    input  row
  );

  modport responder (
    input  req,
    input  idx,
    output ack,
    output row
  );

endinterface

`default_nettype wire

/* verilog/weight_rom.sv */
`default_nettype none

`include "dense_settings.svh"

module weight_rom (
  input wire clk,
  input wire rst_n,
  weight_fetch_if.responder fetch
);

  // trained output weights in Q8.8, word 0 multiplies hid[0]
  function automatic dense_pkg::hid_vec_t rom_row(input dense_pkg::char_idx_t sel);
    dense_pkg::hid_vec_t r;
    r = '0;
    case (sel)
      2'd0: begin
        r[0] = 16'sh0080;  // 0.5
        r[1] = 16'shfec0;  // -1.25
        r[2] = 16'sh0200;  // 2.0
        r[3] = 16'sh00c0;  // 0.75
      end
      2'd1: begin
        r[0] = 16'shff80;  // -0.5
        r[1] = 16'sh0100;  // 1.0
        r[2] = 16'shfc80;  // -3.5
        r[3] = 16'sh0040;  // 0.25
      end
      2'd2: begin
        // large weights, these rows make the sum wrap
        r[0] = 16'sh4000;  // 64.0
        r[1] = 16'shffe0;  // -0.125
        r[2] = 16'sh0180;  // 1.5
        r[3] = 16'she000;  // -32.0
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  logic new_req;

  assign new_req = fetch.req && !fetch.ack;  // rising phase of the handshake

  // ack follows req with one cycle of delay in both directions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch.ack <= 1'b0;
    end else if (new_req) begin
      fetch.ack <= 1'b1;
    end else if (!fetch.req && fetch.ack) begin
      fetch.ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (new_req) begin
      fetch.row <= rom_row(fetch.idx);  // held until next fetch
    end
  end

  // the sequencer must never ask for a row past the last character
  a_idx_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch.req |-> (fetch.idx < `DENSE_CHAR_NUM)
  );

endmodule

`default_nettype wire

/* verilog/dot_product.sv */
`default_nettype none

`include "dense_settings.svh"

module dot_product (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_valid,
  input  wire dense_pkg::char_idx_t  in_tag,
  input  wire dense_pkg::hid_vec_t   hid,
  input  wire dense_pkg::hid_vec_t   weight,
  output logic                       out_valid,
  output dense_pkg::char_idx_t       out_tag,
  output dense_pkg::word_t           out_score
);

  localparam int HALF = `DENSE_HID_DIM / 2;

  logic signed [2*`DENSE_N_LEN-1:0] prod_q [`DENSE_HID_DIM];  // full width products
  dense_pkg::word_t shift_q [`DENSE_HID_DIM];
  dense_pkg::word_t part_q [HALF];
  dense_pkg::word_t tree_sum;
  dense_pkg::word_t sum_q;

  logic [`DENSE_DOT_STAGES-1:0] valid_pipe;
  dense_pkg::char_idx_t tag_pipe [`DENSE_DOT_STAGES];

  // stage 1 multiply, stage 2 shift
  always_ff @(posedge clk) begin
    for (int j = 0; j < `DENSE_HID_DIM; j++) begin
      prod_q[j]  <= $signed(hid[j]) * $signed(weight[j]);
      // arithmetic shift truncates toward minus infinity, then keep low word
      shift_q[j] <= dense_pkg::word_t'(prod_q[j] >>> `DENSE_FRAC_BITS);
    end
  end

  // stage 3 pairwise adds
  always_ff @(posedge clk) begin
    for (int p = 0; p < HALF; p++) begin
      part_q[p] <= shift_q[2*p] + shift_q[2*p+1];  // wraps at word width
    end
  end

  // stage 4 adds the partial sums
  always_comb begin
    tree_sum = '0;
    for (int p = 0; p < HALF; p++) begin
      tree_sum = tree_sum + part_q[p];
    end
  end

  always_ff @(posedge clk) begin
    sum_q <= tree_sum;
  end

  // valid and tag travel next to the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`DENSE_DOT_STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    tag_pipe[0] <= in_tag;
    for (int s = 1; s < `DENSE_DOT_STAGES; s++) begin
      tag_pipe[s] <= tag_pipe[s-1];
    end
  end

  assign out_valid = valid_pipe[`DENSE_DOT_STAGES-1];
  assign out_tag   = tag_pipe[`DENSE_DOT_STAGES-1];
  assign out_score = sum_q;

  // fixed latency, never stalls
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> ##(`DENSE_DOT_STAGES) out_valid
  );

endmodule

`default_nettype wire

/* verilog/dense_layer.sv */
`default_nettype none

`include "dense_settings.svh"

module dense_layer (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire                                    req,
  input  wire dense_pkg::hid_vec_t [`DENSE_N-1:0] d,
  output logic                                   ack,
  output dense_pkg::word_t [`DENSE_N-1:0][`DENSE_CHAR_NUM-1:0] q,
  weight_fetch_if.requester                      fetch
);

  localparam dense_pkg::char_idx_t LAST_CHAR = dense_pkg::char_idx_t'(`DENSE_CHAR_NUM - 1);

  dense_pkg::layer_state_e state;
  dense_pkg::char_idx_t    char_idx;     // character being fetched or issued
  dense_pkg::char_idx_t    pending;      // characters still inside the dot units
  dense_pkg::char_idx_t    pending_nxt;
  dense_pkg::hid_vec_t     w_row;        // latched weight row
  logic                    fetch_req;
  logic                    issue;

  logic [`DENSE_N-1:0]     dot_valid;
  dense_pkg::char_idx_t    dot_tag [`DENSE_N];
  dense_pkg::word_t        dot_score [`DENSE_N];

  dense_pkg::word_t [`DENSE_N-1:0][`DENSE_CHAR_NUM-1:0] score_q;

  assign issue = (state == dense_pkg::ST_ISSUE);

  // every unit moves in lockstep so unit 0 stands for all of them
  assign pending_nxt = pending + dense_pkg::char_idx_t'(issue)
                               - dense_pkg::char_idx_t'(dot_valid[0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= dense_pkg::ST_IDLE;
      char_idx  <= '0;
      fetch_req <= 1'b0;
    end else begin
      case (state)
        dense_pkg::ST_IDLE: begin
          if (req) begin
            char_idx <= '0;
            state    <= dense_pkg::ST_FETCH;
          end
        end
        dense_pkg::ST_FETCH: begin
          if (fetch_req && fetch.ack) begin
            fetch_req <= 1'b0;  // row is captured on this edge
            state     <= dense_pkg::ST_ISSUE;
          end else if (!fetch_req && !fetch.ack) begin
            fetch_req <= 1'b1;  // previous handshake fully closed
          end
        end
        dense_pkg::ST_ISSUE: begin
          if (char_idx == LAST_CHAR) begin
            state <= dense_pkg::ST_DRAIN;
          end else begin
            char_idx <= char_idx + 1'b1;
            state    <= dense_pkg::ST_FETCH;
          end
        end
        dense_pkg::ST_DRAIN: begin
          // last score lands on this edge, ack follows right after
          if (pending_nxt == '0) begin
            state <= dense_pkg::ST_DONE;
          end
        end
        dense_pkg::ST_DONE: begin
          if (!req) begin
            state <= dense_pkg::ST_IDLE;
          end
        end
        default: state <= dense_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req && fetch.ack) begin
      w_row <= fetch.row;
    end
  end

  // scores land at row i, column given by the tag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_q <= '0;
    end else begin
      for (int i = 0; i < `DENSE_N; i++) begin
        if (dot_valid[i]) begin
          score_q[i][dot_tag[i]] <= dot_score[i];
        end
      end
    end
  end

  assign fetch.req = fetch_req;
  assign fetch.idx = char_idx;
  assign ack       = (state == dense_pkg::ST_DONE);
  assign q         = score_q;  // every column rewritten per job

  for (genvar i = 0; i < `DENSE_N; i++) begin : g_dot
    dot_product u_dot (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (issue),
      .in_tag    (char_idx),
      .hid       (d[i]),
      .weight    (w_row),
      .out_valid (dot_valid[i]),
      .out_tag   (dot_tag[i]),
      .out_score (dot_score[i])
    );

    a_tag_in_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      dot_valid[i] |-> (dot_tag[i] < `DENSE_CHAR_NUM)
    );
  end

  // ack only answers a pending host request
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> req
  );

endmodule

`default_nettype wire

/* verilog/dense_top.sv */
`default_nettype none

`include "dense_settings.svh"

module dense_top (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire                                    req,    // host four-phase request
  input  wire dense_pkg::hid_vec_t [`DENSE_N-1:0] d,      // batch of hidden vectors
  output logic                                   ack,
  output dense_pkg::word_t [`DENSE_N-1:0][`DENSE_CHAR_NUM-1:0] q  // score matrix
);

  // weight row fetch between sequencer and ROM
  weight_fetch_if u_fetch ();

  dense_layer u_layer (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .d     (d),
    .ack   (ack),
    .q     (q),
    .fetch (u_fetch.requester)
  );

  weight_rom u_rom (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (u_fetch.responder)
  );

endmodule

`default_nettype wire

/* sim/tb_dense_top.sv */
`default_nettype none

`include "dense_settings.svh"

module tb_dense_top;

  localparam int PERIOD        = 100;
  localparam int NREC          = 7;
  localparam int D_WORDS       = `DENSE_N * `DENSE_HID_DIM;
  localparam int Q_WORDS       = `DENSE_N * `DENSE_CHAR_NUM;
  localparam int REC_WORDS     = D_WORDS + Q_WORDS;
  localparam int Q_BITS        = Q_WORDS * `DENSE_N_LEN;
  localparam int MAX_WAIT      = 40;  // cycles from req to ack
  localparam int MAX_RELEASE   = 3;   // cycles from req low to ack low
  localparam int JOB_CYCLES    = 60;  // one job with its gap and hold
  localparam int NJOBS         = 2 * NREC - 1;
  localparam int WATCHDOG_TIME = (NJOBS + 2) * JOB_CYCLES * PERIOD;

  logic clk;
  logic rst_n;
  logic req;
  dense_pkg::hid_vec_t [`DENSE_N-1:0] d;
  logic ack;
  dense_pkg::word_t [`DENSE_N-1:0][`DENSE_CHAR_NUM-1:0] q;

  // raw words from the data file, then split into records
  logic [`DENSE_N_LEN-1:0] mem [NREC*REC_WORDS];
  dense_pkg::hid_vec_t [`DENSE_N-1:0] rec_d [NREC];
  dense_pkg::word_t [`DENSE_N-1:0][`DENSE_CHAR_NUM-1:0] rec_q [NREC];

  integer seed;

  dense_top u_dense_top (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .d     (d),
    .ack   (ack),
    .q     (q)
  );

  always #(PERIOD/2) clk = ~clk;

  task automatic check_value(input logic [Q_BITS-1:0] got, input logic [Q_BITS-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("error at %0t: %s", $time, why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic unpack_records;
    int base;
    for (int r = 0; r < NREC; r++) begin
      base = r * REC_WORDS;
      for (int i = 0; i < `DENSE_N; i++) begin
        for (int j = 0; j < `DENSE_HID_DIM; j++) begin
          rec_d[r][i][j] = mem[base + i*`DENSE_HID_DIM + j];
        end
        for (int c = 0; c < `DENSE_CHAR_NUM; c++) begin
          rec_q[r][i][c] = mem[base + D_WORDS + i*`DENSE_CHAR_NUM + c];
        end
      end
    end
  endtask

  // one host job with a random idle gap before and random back-pressure after
  task automatic run_job(input int r);
    int gap;
    int hold;
    int waited;
    gap  = $unsigned($random(seed)) % 5;
    hold = $unsigned($random(seed)) % 6;
    repeat (gap) @(posedge clk);
    @(negedge clk);
    check_value(Q_BITS'(ack), '0, "ack high before request");
    @(posedge clk);
    req <= 1'b1;
    d   <= rec_d[r];
    waited = 0;
    @(negedge clk);
    while (!ack) begin
      waited++;
      if (waited > MAX_WAIT) begin
        stop_run($sformatf("ack never rose for record %0d", r));
      end
      @(negedge clk);
    end
    for (int i = 0; i < `DENSE_N; i++) begin
      for (int c = 0; c < `DENSE_CHAR_NUM; c++) begin
        check_value(Q_BITS'(q[i][c]), Q_BITS'(rec_q[r][i][c]),
                    $sformatf("record %0d row %0d char %0d", r, i, c));
      end
    end
    repeat (hold) begin
      @(negedge clk);
      check_value(Q_BITS'(ack), Q_BITS'(1'b1), "ack dropped while req still high");
      check_value(q, rec_q[r], $sformatf("q moved under back-pressure, record %0d", r));
    end
    @(posedge clk);
    req <= 1'b0;
    d   <= {$random(seed), $random(seed), $random(seed), $random(seed)};  // junk between jobs
    waited = 0;
    @(negedge clk);
    while (ack) begin
      waited++;
      if (waited > MAX_RELEASE) begin
        stop_run($sformatf("ack stayed high after req dropped, record %0d", r));
      end
      @(negedge clk);
    end
  endtask

  initial begin
    int fd;
    seed  = 32'hd892_7555;
    clk   = 1'b0;
    rst_n = 1'b0;
    req   = 1'b0;
    d     = '0;
    fd = $fopen("sim/dense_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open sim/dense_testdata.txt");
    end
    $fclose(fd);
    $readmemh("sim/dense_testdata.txt", mem);
    unpack_records();

    // reset spans two rising edges
    @(posedge clk);
    @(negedge clk);
    check_value(Q_BITS'(ack), '0, "ack high during reset");
    check_value(q, '0, "q not zero during reset");
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value(Q_BITS'(ack), '0, "ack high after reset");
    check_value(q, '0, "q not zero after reset");

    for (int r = 0; r < NREC; r++) begin
      run_job(r);
    end
    // reverse order so each job follows a different one
    for (int r = NREC - 2; r >= 0; r--) begin
      run_job(r);
    end

    @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: run still going after %0d time units", WATCHDOG_TIME);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* sim/dense_testdata.txt */
// one record per line: d row0 w0..w3, d row1 w0..w3,
// then expected q row0 c0..c2, q row1 c0..c2, all Q8.8 hex words
// single unit input
0000 0000 0000 0000 0100 0000 0000 0000 0000 0000 0000 0080 ff80 4000
// all ones, then 2.0 / -1.0 / 0.5 with an overflowing product
0100 0100 0100 0100 0200 ff00 0080 0000 0200 fd40 2160 0340 fc40 80e0
// tiny negatives truncate toward minus infinity, row 1 at full scale
ffff 0001 fff0 0003 8000 7fff 0000 0000 ffdf 0039 ff47 2001 bfff f000
0180 fe00 0040 ff00 0010 0020 ffc0 0008 0300 fc20 80a0 ff66 00fa 029c
// largest positive and most negative words
7fff 7fff 7fff 7fff 8000 8000 8000 8000 fffd a001 afde 0000 6000 5000
0000 0100 0000 0000 0000 0000 0000 0100 fec0 0100 ffe0 00c0 0040 e000
0300 0300 0300 0300 fd00 fd00 fd00 fd00 0600 f7c0 6420 fa00 0840 9be0

/* sim.f */
+incdir+include
verilog/dense_pkg.sv
verilog/weight_fetch_if.sv
verilog/weight_rom.sv
verilog/dot_product.sv
verilog/dense_layer.sv
verilog/dense_top.sv
sim/tb_dense_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the dense layer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dense_top -f sim.f \
  --Mdir obj_dir -o tb_dense_top \
  && ./obj_dir/tb_dense_top \
  && echo "simulation finished" \
  || { echo "simulation failed"; exit 1; }
